/* common/rd_product_defines.svh */
// Sizing constants for the read-data product path, included by the package, RTL and testbench
`ifndef RD_PRODUCT_DEFINES_SVH
`define RD_PRODUCT_DEFINES_SVH

// ----------------------------------------
// Beat geometry
// ----------------------------------------

// Lanes per 512-bit read beat
`define RDP_LANES 8

// One operand is half a lane
`define RDP_OPND_W 32
`define RDP_LANE_W 64

// Read id width as seen on the bus
`define RDP_ID_W 6

// ----------------------------------------
// Flow control
// ----------------------------------------

// Beat buffer entries, also the input credits held by the source after reset
`define RDP_FIFO_DEPTH 4

// Most output credits the sink may have outstanding
`define RDP_OUT_CREDITS 8

// Fixed signature word for status checks
`define RDP_STATUS_SIG 32'h5244_5031

`endif

/* common/rd_product_pkg.sv */
// Shared types for the read-data product path, referenced by scoped name from RTL and testbench
`include "rd_product_defines.svh"

package rd_product_pkg;

   // ----------------------------------------
   // Lane word
   // ----------------------------------------

   // Operand pair, a in the upper half and b in the lower half
   typedef struct packed {
      logic [`RDP_OPND_W-1:0] a;
      logic [`RDP_OPND_W-1:0] b;
   } rd_pair_s;

   // Buffered as a raw word, decoded as an operand pair by the multiplier
   typedef union packed {
      logic [`RDP_LANE_W-1:0] raw;
      rd_pair_s               pair;
   } rd_lane_u;

   // Full 512-bit beat, lane 0 in the low bits
   typedef rd_lane_u [`RDP_LANES-1:0] rd_beat_t;

   // ----------------------------------------
   // Beat sideband and full beats
   // ----------------------------------------

   typedef struct packed {
      logic [`RDP_ID_W-1:0] id;
      logic [1:0]           resp;
      logic                 last;
   } rd_meta_t;

   typedef struct packed {
      rd_meta_t meta;
      rd_beat_t beat;
   } rd_in_s;

   // Eight 64-bit products
   typedef logic [`RDP_LANES-1:0][`RDP_LANE_W-1:0] rd_prod_t;

   typedef struct packed {
      rd_meta_t meta;
      rd_prod_t prod;
   } rd_out_s;

endpackage

/* source/rd_flow_ctrl.sv */
// Credit-based flow control for the product path: pop decision, valid shift and FLR response
`timescale 1ns/1ps
`include "rd_product_defines.svh"

module rd_flow_ctrl
(
   input  logic       clk,
   input  logic       sync_rst_n,

   // Buffer status and sink credits
   input  logic       not_empty,
   input  logic       out_credit,

   output logic       pop,
   output logic       in_credit,
   output logic [1:0] stage_vld,

   input  logic       flr_assert,
   output logic       flr_done
);

   localparam int CRED_W = $clog2(`RDP_OUT_CREDITS + 1);

   logic [CRED_W-1:0] credit_cnt;
   logic              credit_avail;
   logic              flr_assert_q;

   // ----------------------------------------
   // Output credits and pop
   // ----------------------------------------

   assign credit_avail = (credit_cnt != '0);

   // A credit is reserved at pop, so the pipeline never has to stall
   assign pop = not_empty && credit_avail;

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         credit_cnt <= '0;
      end
      else
      begin
         case ({out_credit, pop})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            // Grant and spend in one cycle cancel out
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   // ----------------------------------------
   // Pipeline valid shift
   // ----------------------------------------

   // Bit 0 marks stage 1 contents, bit 1 marks the product on the output
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         stage_vld <= 2'b00;
      end
      else
      begin
         stage_vld <= {stage_vld[0], pop};
      end
   end

   // ----------------------------------------
   // Input credit return
   // ----------------------------------------

   // Each pop frees one buffer entry, returned to the source next cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         in_credit <= 1'b0;
      end
      else
      begin
         in_credit <= pop;
      end
   end

   // ----------------------------------------
   // Function-level reset response
   // ----------------------------------------

   // Done toggles while the request stays high
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

/* source/beat_buffer.sv */
// Circular FIFO for incoming read beats, sized to the input credits granted to the source
`timescale 1ns/1ps
`include "rd_product_defines.svh"

module beat_buffer
(
   input  logic                   clk,
   input  logic                   sync_rst_n,

   input  logic                   wr_en,
   input  rd_product_pkg::rd_in_s wr_data,

   input  logic                   pop,
   output rd_product_pkg::rd_in_s rd_data,
   output logic                   not_empty
);

   localparam int PTR_W = $clog2(`RDP_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`RDP_FIFO_DEPTH + 1);

   // Storage, sideband apart from the raw lane words
   rd_product_pkg::rd_meta_t meta_mem [`RDP_FIFO_DEPTH];
   logic [`RDP_LANE_W-1:0]   lane_mem [`RDP_FIFO_DEPTH][`RDP_LANES];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(`RDP_FIFO_DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // ----------------------------------------
   // Storage
   // ----------------------------------------

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         meta_mem[wr_ptr] <= wr_data.meta;
         for (int l = 0; l < `RDP_LANES; l++)
         begin
            lane_mem[wr_ptr][l] <= wr_data.beat[l].raw;
         end
      end
   end

   // Head entry is visible without a read cycle
   always_comb
   begin
      rd_data.meta = meta_mem[rd_ptr];
      for (int l = 0; l < `RDP_LANES; l++)
      begin
         rd_data.beat[l].raw = lane_mem[rd_ptr][l];
      end
   end

   // ----------------------------------------
   // Pointers and occupancy
   // ----------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop)
         begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Follows the registered count, so a write shows one cycle later
   assign not_empty = (count != '0);

endmodule

/* product_array/product_array.sv */
// Two-stage unsigned 32x32 product pipeline over eight lanes, output lanes in reversed order
`timescale 1ns/1ps
`include "rd_product_defines.svh"

module product_array
(
   input  logic                    clk,
   input  logic                    sync_rst_n,

   // Bit 0 loads stage 1, bit 1 loads stage 2
   input  logic [1:0]              stage_en,
   input  rd_product_pkg::rd_in_s  in_data,
   output rd_product_pkg::rd_out_s out_data
);

   rd_product_pkg::rd_beat_t beat_q;
   rd_product_pkg::rd_meta_t meta_q;
   rd_product_pkg::rd_prod_t prod_q;
   rd_product_pkg::rd_meta_t meta_out_q;

   // ----------------------------------------
   // Stage 1: operand capture
   // ----------------------------------------

   always_ff @(posedge clk)
   begin
      if (stage_en[0])
      begin
         beat_q <= in_data.beat;
      end
   end

   // Sideband moves with the same stage enables as the data
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         meta_q     <= '0;
         meta_out_q <= '0;
      end
      else
      begin
         if (stage_en[0])
         begin
            meta_q <= in_data.meta;
         end
         if (stage_en[1])
         begin
            meta_out_q <= meta_q;
         end
      end
   end

   // ----------------------------------------
   // Stage 2: multiply and reverse lanes
   // ----------------------------------------

   // Lane i lands in lane 7-i, matching the bus byte order downstream
   always_ff @(posedge clk)
   begin
      if (stage_en[1])
      begin
         for (int l = 0; l < `RDP_LANES; l++)
         begin
            prod_q[`RDP_LANES-1-l] <= beat_q[l].pair.a * beat_q[l].pair.b;
         end
      end
   end

   assign out_data.meta = meta_out_q;
   assign out_data.prod = prod_q;

endmodule

/* source/rd_product_top.sv */
// Top level of the read-data product path; connects flow control, beat buffer and product array
`timescale 1ns/1ps

module rd_product_top
(
   input  logic                    clk,
   input  logic                    sync_rst_n,

   // Source side
   input  logic                    in_valid,
   input  rd_product_pkg::rd_in_s  in_beat,
   output logic                    in_credit,

   // Sink side
   output logic                    out_valid,
   output rd_product_pkg::rd_out_s out_beat,
   input  logic                    out_credit,

   // Function-level reset request
   input  logic                    flr_assert,
   output logic                    flr_done
);

   logic                   buf_not_empty;
   logic                   buf_pop;
   rd_product_pkg::rd_in_s buf_rd_data;
   logic [1:0]             stage_vld;
   logic [1:0]             stage_en;

   // ----------------------------------------
   // Credit and pipeline control
   // ----------------------------------------

   rd_flow_ctrl u_flow_ctrl
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .not_empty  (buf_not_empty),
      .out_credit (out_credit),
      .pop        (buf_pop),
      .in_credit  (in_credit),
      .stage_vld  (stage_vld),
      .flr_assert (flr_assert),
      .flr_done   (flr_done)
   );

   // ----------------------------------------
   // Input beat buffer
   // ----------------------------------------

   beat_buffer u_beat_buffer
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .wr_en      (in_valid),
      .wr_data    (in_beat),
      .pop        (buf_pop),
      .rd_data    (buf_rd_data),
      .not_empty  (buf_not_empty)
   );

   // ----------------------------------------
   // Product pipeline
   // ----------------------------------------

   // Stage 1 loads on the pop itself, stage 2 one cycle later
   assign stage_en = {stage_vld[0], buf_pop};

   product_array u_product_array
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .stage_en   (stage_en),
      .in_data    (buf_rd_data),
      .out_data   (out_beat)
   );

   // Stage 2 holds a valid product two cycles after its pop
   assign out_valid = stage_vld[1];

endmodule

/* tests/rd_product_checks.svh */
// Compare tasks for the product path testbench, included inside the testbench module
`ifndef RD_PRODUCT_CHECKS_SVH
`define RD_PRODUCT_CHECKS_SVH

// ----------------------------------------
// Output beats
// ----------------------------------------

// Sideband first, then every product lane on its own
task automatic check_out(input rd_product_pkg::rd_out_s got,
                         input rd_product_pkg::rd_out_s exp,
                         input string what);
   int l;
   if (got.meta !== exp.meta)
   begin
      report_failure($sformatf("CHECK FAILED at %0t: %s id/resp/last %0h/%0h/%0b, expected %0h/%0h/%0b",
                               $time, what, got.meta.id, got.meta.resp, got.meta.last,
                               exp.meta.id, exp.meta.resp, exp.meta.last));
   end
   for (l = 0; l < `RDP_LANES; l++)
   begin
      if (got.prod[l] !== exp.prod[l])
      begin
         report_failure($sformatf("CHECK FAILED at %0t: %s lane %0d got %h, expected %h",
                                  $time, what, l, got.prod[l], exp.prod[l]));
      end
   end
endtask

// ----------------------------------------
// Control levels and counts
// ----------------------------------------

task automatic check_bit(input logic got, input logic exp, input string what);
   if (got !== exp)
   begin
      report_failure($sformatf("CHECK FAILED at %0t: %s got %b, expected %b",
                               $time, what, got, exp));
   end
endtask

// Beat and credit tallies
task automatic check_count(input int got, input int exp, input string what);
   if (got != exp)
   begin
      report_failure($sformatf("CHECK FAILED at %0t: %s got %0d, expected %0d",
                               $time, what, got, exp));
   end
endtask

`endif

/* tests/rd_product_tb.sv */
// Random testbench for the product path; compile with rd_product_top.f, top rd_product_tb
`timescale 1ns/1ps
`include "rd_product_defines.svh"

module rd_product_tb;

   logic                    clk;
   logic                    sync_rst_n;
   logic                    in_valid;
   rd_product_pkg::rd_in_s  in_beat;
   logic                    in_credit;
   logic                    out_valid;
   rd_product_pkg::rd_out_s out_beat;
   logic                    out_credit;
   logic                    flr_assert;
   logic                    flr_done;

   integer seed;
   int     src_credits;
   int     sink_out;
   int     beats_sent;
   int     beats_seen;
   int     credits_back;
   int     src_rate;
   int     sink_rate;
   logic   flr_q_model;
   logic   flr_done_model;
   int     cyc;
   rd_product_pkg::rd_out_s exp_q[$];

   initial clk = 1'b0;
   always #2 clk = ~clk;

   rd_product_top dut
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_valid   (in_valid),
      .in_beat    (in_beat),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_beat   (out_beat),
      .out_credit (out_credit),
      .flr_assert (flr_assert),
      .flr_done   (flr_done)
   );

   task automatic report_failure(input string text);
      $display("%s", text);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

`include "rd_product_checks.svh"

   // Percent chance drawn from the seeded stream, a zero rate draws nothing
   function automatic bit chance(input int pct);
      if (pct <= 0)
      begin
         return 1'b0;
      end
      return ($unsigned($random(seed)) % 100) < pct;
   endfunction

   // Lanes mix all-ones, one all-ones operand, a zero operand and plain random words
   function automatic rd_product_pkg::rd_in_s random_beat();
      rd_product_pkg::rd_in_s b;
      int l;
      b.meta.id   = $random(seed);
      b.meta.resp = $random(seed);
      b.meta.last = $random(seed);
      for (l = 0; l < `RDP_LANES; l++)
      begin
         case ($unsigned($random(seed)) % 6)
            0:       b.beat[l].raw = '1;
            1:       b.beat[l].raw = {32'hffff_ffff, 32'($random(seed))};
            2:       b.beat[l].raw = {32'($random(seed)), 32'h0};
            default: b.beat[l].raw = {32'($random(seed)), 32'($random(seed))};
         endcase
      end
      return b;
   endfunction

   // Upper half times lower half, input lane i lands in output lane 7-i
   function automatic rd_product_pkg::rd_out_s expected_out(input rd_product_pkg::rd_in_s b);
      rd_product_pkg::rd_out_s e;
      logic [63:0] hi;
      logic [63:0] lo;
      int l;
      e.meta = b.meta;
      for (l = 0; l < `RDP_LANES; l++)
      begin
         hi = {32'h0, b.beat[l].raw[63:32]};
         lo = {32'h0, b.beat[l].raw[31:0]};
         e.prod[`RDP_LANES-1-l] = hi * lo;
      end
      return e;
   endfunction

   // Reference for the FLR done pulse
   always @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_q_model    <= 1'b0;
         flr_done_model <= 1'b0;
      end
      else
      begin
         flr_q_model    <= flr_assert;
         flr_done_model <= flr_q_model && !flr_done_model;
      end
   end

   // ----------------------------------------
   // Source, sink and scoreboard
   // ----------------------------------------

   always @(negedge clk)
   begin : source_sink
      rd_product_pkg::rd_in_s b;
      if (!sync_rst_n)
      begin
         check_bit(out_valid, 1'b0, "out_valid in reset");
         check_bit(in_credit, 1'b0, "in_credit in reset");
         check_bit(flr_done, 1'b0, "flr_done in reset");
         in_valid    = 1'b0;
         out_credit  = 1'b0;
         src_credits = `RDP_FIFO_DEPTH;
         sink_out    = 0;
      end
      else
      begin
         check_bit(flr_done, flr_done_model, "flr_done");
         if (in_credit)
         begin
            src_credits++;
            credits_back++;
         end
         if (out_valid)
         begin
            check_bit(sink_out > 0, 1'b1, "out_valid backed by a granted credit");
            sink_out--;
            if (exp_q.size() == 0)
            begin
               report_failure("An output beat arrived while no beat was expected");
            end
            check_out(out_beat, exp_q.pop_front(), "output beat");
            beats_seen++;
         end
         check_bit(src_credits >= 0 && src_credits <= `RDP_FIFO_DEPTH, 1'b1,
                   "source credit balance within range");
         in_valid   = 1'b0;
         out_credit = 1'b0;
         if (src_credits > 0 && chance(src_rate))
         begin
            b        = random_beat();
            in_beat  = b;
            in_valid = 1'b1;
            exp_q.push_back(expected_out(b));
            src_credits--;
            beats_sent++;
         end
         if (sink_out < `RDP_OUT_CREDITS && chance(sink_rate))
         begin
            out_credit = 1'b1;
            sink_out++;
         end
      end
   end

   // Rates change between falling edges so the random stream stays fixed
   task automatic set_rates(input int src, input int sink);
      @(posedge clk);
      src_rate  = src;
      sink_rate = sink;
   endtask

   task automatic wait_sent(input int target, input int limit);
      int n;
      for (n = 0; n < limit && beats_sent < target; n++)
      begin
         @(posedge clk);
      end
      if (beats_sent < target)
      begin
         report_failure($sformatf("Timeout at %0t while waiting for %0d beats to be sent",
                                  $time, target));
      end
   endtask

   task automatic wait_drained(input int limit);
      int n;
      for (n = 0; n < limit && exp_q.size() != 0; n++)
      begin
         @(posedge clk);
      end
      if (exp_q.size() != 0)
      begin
         report_failure("Timeout while waiting for the queued beats to come out");
      end
   endtask

   task automatic wait_stalled(input int limit);
      int n;
      for (n = 0; n < limit && !(sink_out == 0 && src_credits == 0); n++)
      begin
         @(posedge clk);
      end
      if (sink_out != 0 || src_credits != 0)
      begin
         report_failure("Timeout while waiting for the source to stall on credits");
      end
   endtask

   task automatic wait_flr_done(input int limit);
      int n;
      for (n = 0; n < limit && flr_done !== 1'b1; n++)
      begin
         @(negedge clk);
      end
      if (flr_done !== 1'b1)
      begin
         report_failure("Timeout while waiting for flr_done after a reset request");
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------

   initial
   begin
      seed = 73;
      sync_rst_n = 1'b0;
      in_valid = 1'b0;
      in_beat = '0;
      out_credit = 1'b0;
      flr_assert = 1'b0;
      src_rate = 0;
      sink_rate = 0;
      beats_sent = 0;
      beats_seen = 0;
      credits_back = 0;
      $display("Product path test, status signature %h", `RDP_STATUS_SIG);
      repeat (10) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         check_bit(out_valid, 1'b0, "out_valid after reset");
         check_bit(in_credit, 1'b0, "in_credit after reset");
      end

      // Single-cycle request, then a held one where done toggles
      flr_assert = 1'b1;
      @(negedge clk);
      flr_assert = 1'b0;
      wait_flr_done(10);
      flr_assert = 1'b1;
      @(negedge clk);
      wait_flr_done(10);
      // Done is high here, so it reads low, high, low and so on
      for (cyc = 0; cyc < 10; cyc++)
      begin
         @(negedge clk);
         check_bit(flr_done, (cyc % 2) == 1, "flr_done alternates while held");
      end
      flr_assert = 1'b0;

      set_rates(60, 50);
      wait_sent(300, 5000);
      set_rates(100, 100);
      wait_sent(500, 2000);

      // Withhold credits until the buffer fills and the source runs dry
      set_rates(100, 0);
      wait_stalled(300);
      check_count(exp_q.size(), `RDP_FIFO_DEPTH, "beats waiting in the buffer");
      for (cyc = 0; cyc < 40; cyc++)
      begin
         @(negedge clk);
         check_bit(out_valid, 1'b0, "out_valid with credits withheld");
         check_bit(in_credit, 1'b0, "in_credit with credits withheld");
      end

      set_rates(0, 70);
      wait_drained(500);
      set_rates(0, 0);
      repeat (4) @(posedge clk);
      check_count(credits_back, beats_sent, "in_credit pulses");
      check_count(beats_seen, beats_sent, "output beats");
      check_count(src_credits, `RDP_FIFO_DEPTH, "source credits at the end");
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* rd_product_top.f */
+incdir+common
+incdir+tests
common/rd_product_pkg.sv
source/rd_flow_ctrl.sv
source/beat_buffer.sv
product_array/product_array.sv
source/rd_product_top.sv
tests/rd_product_tb.sv
